/* rtl/ifu_pkg.sv */
package ifu_pkg;

  // address and data widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // fetch starts here after reset
  localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0000;

  // cache geometry, pc = {tag[31:6], idx[5:3], word[2], byte[1:0]}
  localparam int ICACHE_LINES = 8;
  localparam int IDX_W = 3;
  localparam int TAG_W = 26;
  localparam int LINE_WORDS = 2;
  // byte offset bits inside one line
  localparam int OFF_W = 3;

  // instruction memory, 256 words at pc[9:2]
  localparam int MEM_AW = 8;
  localparam int MEM_LATENCY = 2;
  // width of the memory latency counter
  localparam int LAT_W = 2;

  // fence.i flushes the whole cache
  localparam logic [DATA_W-1:0] FENCE_I_INST = 32'h0000_100f;

  // cache refill sequence
  typedef enum logic [1:0] {
    idle,
    wait_w0,
    req_w1,
    wait_w1
  } icache_state_e;

  // memory read channel
  typedef enum logic {
    mem_idle,
    mem_busy
  } mem_state_e;

endpackage

/* rtl/ifu_pc_gen.sv */
`timescale 1ns/1ps

module ifu_pc_gen import ifu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid_i,
  input  logic              next_ready_i,
  input  logic              redirect_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  output logic [ADDR_W-1:0] pc_o
);

  logic [ADDR_W-1:0] pc_q;
  logic              handover;

  // instruction leaves fetch this cycle
  assign handover = valid_i && next_ready_i;

  // redirect wins over the sequential step
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= RESET_PC;
    end
    else if (redirect_i)
    begin
      pc_q <= redirect_pc_i;
    end
    else if (handover)
    begin
      pc_q <= pc_q + ADDR_W'(4);
    end
  end

  assign pc_o = pc_q;

endmodule

/* rtl/ifu_icache.sv */
`timescale 1ns/1ps

module ifu_icache import ifu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] pc_i,
  input  logic              next_ready_i,
  output logic              valid_o,
  output logic [DATA_W-1:0] inst_o,
  output logic [ADDR_W-1:0] araddr_o,
  output logic              arvalid_o,
  input  logic [DATA_W-1:0] rdata_i,
  input  logic              rvalid_i
);

  // storage
  logic [DATA_W-1:0]       data_q [ICACHE_LINES][LINE_WORDS];
  logic [TAG_W-1:0]        tag_q [ICACHE_LINES];
  logic [ICACHE_LINES-1:0] valid_q;

  icache_state_e state_q;

  // low in the cycle after reset, then fetch runs
  logic run_q;

  // line being refilled, latched at the miss
  logic [ADDR_W-OFF_W-1:0] line_addr_q;
  logic [IDX_W-1:0]        line_idx;
  logic [TAG_W-1:0]        line_tag;

  // pc fields
  logic [TAG_W-1:0] pc_tag;
  logic [IDX_W-1:0] pc_idx;
  logic             pc_word;

  logic hit;
  logic handover;

  assign pc_tag  = pc_i[ADDR_W-1:ADDR_W-TAG_W];
  assign pc_idx  = pc_i[OFF_W+IDX_W-1:OFF_W];
  assign pc_word = pc_i[OFF_W-1];

  assign line_idx = line_addr_q[IDX_W-1:0];
  assign line_tag = line_addr_q[ADDR_W-OFF_W-1:IDX_W];

  // lookup only while no refill is in flight
  assign hit = run_q && (state_q == idle) && valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);

  assign valid_o  = hit;
  assign inst_o   = data_q[pc_idx][pc_word];
  assign handover = valid_o && next_ready_i;

  // even word straight from pc, odd word from the latched line
  assign arvalid_o = (run_q && (state_q == idle) && !hit) || (state_q == req_w1);
  assign araddr_o  = (state_q == idle) ? {pc_i[ADDR_W-1:OFF_W], 3'b000}
                                       : {line_addr_q, 3'b100};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      run_q <= 1'b0;
    end
    else
    begin
      run_q <= 1'b1;
    end
  end

  // refill state machine
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= idle;
      valid_q <= '0;
    end
    else
    begin
      case (state_q)
        idle:
        begin
          if (arvalid_o)
          begin
            state_q <= wait_w0;
          end
        end
        wait_w0:
        begin
          if (rvalid_i)
          begin
            state_q <= req_w1;
          end
        end
        req_w1:
        begin
          state_q <= wait_w1;
        end
        wait_w1:
        begin
          if (rvalid_i)
          begin
            state_q           <= idle;
            valid_q[line_idx] <= 1'b1;
          end
        end
        default:
        begin
          state_q <= idle;
        end
      endcase

      // fence.i only hands over from idle, so it never meets a refill
      if (handover && (inst_o == FENCE_I_INST))
      begin
        valid_q <= '0;
      end
    end
  end

  // line address and array writes
  always_ff @(posedge clk)
  begin
    if ((state_q == idle) && arvalid_o)
    begin
      line_addr_q <= pc_i[ADDR_W-1:OFF_W];
    end
    if ((state_q == wait_w0) && rvalid_i)
    begin
      data_q[line_idx][0] <= rdata_i;
      tag_q[line_idx]     <= line_tag;
    end
    if ((state_q == wait_w1) && rvalid_i)
    begin
      data_q[line_idx][1] <= rdata_i;
    end
  end

endmodule

/* rtl/imem_bus.sv */
`timescale 1ns/1ps

module imem_bus import ifu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] araddr_i,
  input  logic              arvalid_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              rvalid_o,
  input  logic              mem_we_i,
  input  logic [MEM_AW-1:0] mem_waddr_i,
  input  logic [DATA_W-1:0] mem_wdata_i
);

  logic [DATA_W-1:0] mem_q [2**MEM_AW];

  mem_state_e        state_q;
  logic [MEM_AW-1:0] raddr_q;
  logic [LAT_W-1:0]  lat_cnt_q;

  // load port, one word per cycle
  always_ff @(posedge clk)
  begin
    if (mem_we_i)
    begin
      mem_q[mem_waddr_i] <= mem_wdata_i;
    end
  end

  // read channel
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= mem_idle;
      rvalid_o  <= 1'b0;
      lat_cnt_q <= '0;
    end
    else
    begin
      rvalid_o <= 1'b0;
      case (state_q)
        mem_idle:
        begin
          if (arvalid_i)
          begin
            state_q <= mem_busy;
            // the response register adds the last cycle
            lat_cnt_q <= LAT_W'(MEM_LATENCY - 2);
          end
        end
        mem_busy:
        begin
          if (lat_cnt_q == '0)
          begin
            state_q  <= mem_idle;
            rvalid_o <= 1'b1;
          end
          else
          begin
            lat_cnt_q <= lat_cnt_q - 1'b1;
          end
        end
        default:
        begin
          state_q <= mem_idle;
        end
      endcase
    end
  end

  // word address and read data
  always_ff @(posedge clk)
  begin
    if ((state_q == mem_idle) && arvalid_i)
    begin
      raddr_q <= araddr_i[MEM_AW+1:2];
    end
    if ((state_q == mem_busy) && (lat_cnt_q == '0))
    begin
      rdata_o <= mem_q[raddr_q];
    end
  end

endmodule

/* rtl/ifu_top.sv */
`timescale 1ns/1ps

module ifu_top import ifu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              redirect_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  input  logic              next_ready_i,
  output logic              valid_o,
  output logic [DATA_W-1:0] inst_o,
  output logic [ADDR_W-1:0] pc_o,
  input  logic              mem_we_i,
  input  logic [MEM_AW-1:0] mem_waddr_i,
  input  logic [DATA_W-1:0] mem_wdata_i
);

  logic [ADDR_W-1:0] pc;
  logic              valid;

  // cache to memory read bus
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic [DATA_W-1:0] rdata;
  logic              rvalid;

  assign pc_o    = pc;
  assign valid_o = valid;

  ifu_pc_gen ifu_pc_gen_inst (
    .clk           (clk),
    .rst           (rst),
    .valid_i       (valid),
    .next_ready_i  (next_ready_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (pc)
  );

  ifu_icache ifu_icache_inst (
    .clk          (clk),
    .rst          (rst),
    .pc_i         (pc),
    .next_ready_i (next_ready_i),
    .valid_o      (valid),
    .inst_o       (inst_o),
    .araddr_o     (araddr),
    .arvalid_o    (arvalid),
    .rdata_i      (rdata),
    .rvalid_i     (rvalid)
  );

  imem_bus imem_bus_inst (
    .clk         (clk),
    .rst         (rst),
    .araddr_i    (araddr),
    .arvalid_i   (arvalid),
    .rdata_o     (rdata),
    .rvalid_o    (rvalid),
    .mem_we_i    (mem_we_i),
    .mem_waddr_i (mem_waddr_i),
    .mem_wdata_i (mem_wdata_i)
  );

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o
);

  // 8 ns period, first rising edge at 4 ns
  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #4 clk_o = ~clk_o;
    end
  end

endmodule

/* tests/ifu_sva.sv */
`timescale 1ns/1ps

module ifu_sva import ifu_pkg::*; (
  input logic                    clk,
  input logic                    rst,
  input icache_state_e           state_q,
  input logic [ADDR_W-OFF_W-1:0] line_addr_q,
  input logic [ADDR_W-1:0]       pc_i,
  input logic                    next_ready_i,
  input logic                    valid_o,
  input logic [DATA_W-1:0]       inst_o,
  input logic                    arvalid_o,
  input logic                    rvalid_i
);

  // request is a single-cycle pulse
  arvalid_pulse_a: assert property (@(posedge clk) disable iff (rst)
    arvalid_o |=> !arvalid_o)
    else $error("arvalid high in two consecutive cycles");

  // responses only arrive while a refill waits for them
  rvalid_state_a: assert property (@(posedge clk) disable iff (rst)
    rvalid_i |-> (state_q != idle))
    else $error("rvalid seen while the cache is idle");

  // finished refill of the line under pc hits in the next cycle
  refill_hit_a: assert property (@(posedge clk) disable iff (rst)
    ((state_q == wait_w1) && rvalid_i && (pc_i[ADDR_W-1:OFF_W] == line_addr_q))
      ##1 $stable(pc_i) |-> valid_o)
    else $error("valid not raised after the refill of the line at pc");

  // stalled hit with an unchanged pc keeps its word
  inst_stable_a: assert property (@(posedge clk) disable iff (rst)
    (valid_o && !next_ready_i) ##1 $stable(pc_i) |-> $stable(inst_o))
    else $error("inst changed under back-pressure");

endmodule

bind ifu_icache ifu_sva ifu_sva_inst (
  .clk          (clk),
  .rst          (rst),
  .state_q      (state_q),
  .line_addr_q  (line_addr_q),
  .pc_i         (pc_i),
  .next_ready_i (next_ready_i),
  .valid_o      (valid_o),
  .inst_o       (inst_o),
  .arvalid_o    (arvalid_o),
  .rvalid_i     (rvalid_i)
);

/* tests/ifu_tb.sv */
`timescale 1ns/1ps

module ifu_tb import ifu_pkg::*; ();

  logic              clk;
  logic              rst;
  logic              redirect;
  logic [ADDR_W-1:0] redirect_pc;
  logic              next_ready;
  logic              valid;
  logic [DATA_W-1:0] inst;
  logic [ADDR_W-1:0] pc;
  logic              mem_we;
  logic [MEM_AW-1:0] mem_waddr;
  logic [DATA_W-1:0] mem_wdata;

  // testbench copy of the instruction memory
  logic [DATA_W-1:0] image [2**MEM_AW];

  integer            seed;
  int                errors;
  int                handovers;
  logic [ADDR_W-1:0] exp_pc;
  logic [ADDR_W-1:0] last_pc;
  logic              held;
  logic [ADDR_W-1:0] held_pc;
  logic [DATA_W-1:0] held_inst;

  tb_clock_gen tb_clock_gen_inst (
    .clk_o (clk)
  );

  ifu_top ifu_top_inst (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .next_ready_i  (next_ready),
    .valid_o       (valid),
    .inst_o        (inst),
    .pc_o          (pc),
    .mem_we_i      (mem_we),
    .mem_waddr_i   (mem_waddr),
    .mem_wdata_i   (mem_wdata)
  );

  // word at pc[9:2] of the image
  function automatic logic [DATA_W-1:0] ref_inst(input logic [ADDR_W-1:0] addr);
    return image[addr[9:2]];
  endfunction

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected)
    begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic wait_valid(input int limit);
    int cycles;
    cycles = 0;
    while (!valid)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > limit)
      begin
        $display("timeout at %0t: valid_o did not rise", $time);
        abort_run();
      end
    end
  endtask

  task automatic wait_handovers(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (handovers < target)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > limit)
      begin
        $display("timeout at %0t: only %0d of %0d handovers", $time, handovers, target);
        abort_run();
      end
    end
  endtask

  // called on a falling edge, lets exactly one instruction through
  task automatic take_one();
    int base;
    base = handovers;
    next_ready = 1'b1;
    wait_handovers(base + 1, 60);
    next_ready = 1'b0;
  endtask

  task automatic fetch_at(input logic [ADDR_W-1:0] target);
    @(negedge clk);
    redirect    = 1'b1;
    redirect_pc = target;
    @(negedge clk);
    redirect = 1'b0;
    take_one();
    compare_value("pc_o after redirect", last_pc, target);
  endtask

  task automatic write_word(input int idx, input logic [DATA_W-1:0] data);
    @(negedge clk);
    image[idx] = data;
    mem_we     = 1'b1;
    mem_waddr  = MEM_AW'(idx);
    mem_wdata  = data;
    @(negedge clk);
    mem_we = 1'b0;
  endtask

  // checks every handover and every stalled cycle
  always @(posedge clk)
  begin
    if (rst)
    begin
      exp_pc = RESET_PC;
      held   = 1'b0;
    end
    else
    begin
      if (held)
      begin
        compare_value("valid_o while stalled", valid, 1);
        compare_value("pc_o while stalled", pc, held_pc);
        compare_value("inst_o while stalled", inst, held_inst);
      end
      if (valid && next_ready)
      begin
        compare_value("pc_o", pc, exp_pc);
        compare_value("inst_o", inst, ref_inst(exp_pc));
        last_pc = pc;
        handovers++;
        exp_pc = exp_pc + 4;
      end
      // redirect wins over the +4 step
      if (redirect)
      begin
        exp_pc = redirect_pc;
      end
      held      = valid && !next_ready && !redirect;
      held_pc   = pc;
      held_inst = inst;
    end
  end

  initial
  begin
    logic [DATA_W-1:0] word;
    logic [31:0]       rnd;
    int                base;
    int                cycles;

    seed        = 53408;
    errors      = 0;
    handovers   = 0;
    rst         = 1'b1;
    redirect    = 1'b0;
    redirect_pc = '0;
    next_ready  = 1'b0;
    mem_we      = 1'b0;
    mem_waddr   = '0;
    mem_wdata   = '0;

    // random program, loaded while the core is held in reset
    for (int i = 0; i < 2**MEM_AW; i++)
    begin
      word = $random(seed);
      if (word == FENCE_I_INST)
      begin
        word = ~word;
      end
      write_word(i, word);
    end
    // fence.i at 0x3f8, cache index 7
    write_word(254, FENCE_I_INST);
    repeat (4) @(negedge clk);
    rst = 1'b0;

    // straight-line fetch of 32 words from the reset pc
    next_ready = 1'b1;
    wait_handovers(32, 400);
    next_ready = 1'b0;

    // lines 0x48..0x7f are still cached, expect one handover per cycle
    wait_valid(50);
    @(negedge clk);
    redirect    = 1'b1;
    redirect_pc = 32'h0000_0048;
    @(negedge clk);
    redirect   = 1'b0;
    next_ready = 1'b1;
    base       = handovers;
    repeat (14) @(negedge clk);
    compare_value("handover count", handovers - base, 14);
    next_ready = 1'b0;

    // random back-pressure over 24 handovers
    base   = handovers;
    cycles = 0;
    while (handovers < base + 24)
    begin
      @(negedge clk);
      rnd        = $random(seed);
      next_ready = rnd[0];
      cycles++;
      if (cycles > 1000)
      begin
        $display("timeout at %0t: back-pressure run stuck", $time);
        abort_run();
      end
    end
    next_ready = 1'b0;

    // redirect to 0x280 once the 0x200 refill has started
    wait_valid(50);
    @(negedge clk);
    redirect    = 1'b1;
    redirect_pc = 32'h0000_0200;
    @(negedge clk);
    redirect = 1'b0;
    // 0x200 misses in this cycle, the refill waits for its even word next
    @(negedge clk);
    redirect    = 1'b1;
    redirect_pc = 32'h0000_0280;
    @(negedge clk);
    redirect = 1'b0;
    take_one();
    compare_value("pc_o after redirect in refill", last_pc, 32'h0000_0280);

    // same index, different tags
    for (int i = 0; i < 4; i++)
    begin
      if (i % 2 == 0)
      begin
        fetch_at(32'h0000_0100);
      end
      else
      begin
        fetch_at(32'h0000_0140);
      end
    end

    // change the cached 0x140 line behind the cache, then fence.i
    wait_valid(50);
    write_word(80, ~image[80]);
    write_word(81, ~image[81]);
    fetch_at(32'h0000_03f8);
    fetch_at(32'h0000_0140);
    fetch_at(32'h0000_0144);

    repeat (4) @(negedge clk);
    if (errors == 0)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
    begin
      abort_run();
    end
  end

endmodule

/* verilog.f */
rtl/ifu_pkg.sv
rtl/ifu_pc_gen.sv
rtl/ifu_icache.sv
rtl/imem_bus.sv
rtl/ifu_top.sv
tests/tb_clock_gen.sv
tests/ifu_sva.sv
tests/ifu_tb.sv
